// ==== source/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  // width of pc and instruction words
  localparam int XLEN = 32;

  // first fetch address after reset
  localparam logic [XLEN-1:0] PC_INIT = 32'h8000_0000;

  // major opcodes that stop sequential fetch
  localparam logic [6:0] OP_JAL    = 7'b110_1111;
  localparam logic [6:0] OP_JALR   = 7'b110_0111;
  localparam logic [6:0] OP_BRANCH = 7'b110_0011;
  localparam logic [6:0] OP_LOAD   = 7'b000_0011;

  // fence.i, matched on the whole word
  localparam logic [XLEN-1:0] INST_FENCE_I = 32'h0000_100f;

  // what fetch must do after handing the word to decode
  typedef enum logic [1:0] {
    KIND_SEQ   = 2'd0,
    KIND_CTRL  = 2'd1,
    KIND_LOAD  = 2'd2,
    KIND_FENCE = 2'd3
  } inst_kind_e;

endpackage

`default_nettype wire

// ==== source/l1i_pkg.sv ====
`default_nettype none

package l1i_pkg;

  // two words per line
  localparam int LINE_WORDS = 2;

  // word offset inside a line
  localparam int OFFSET_BITS = 1;

  // refill sequence, one beat outstanding at a time
  typedef enum logic [1:0] {
    RF_IDLE  = 2'd0,
    RF_BEAT0 = 2'd1,
    RF_BEAT1 = 2'd2,
    RF_DONE  = 2'd3
  } refill_state_e;

endpackage

`default_nettype wire

// ==== source/inst_predecode.sv ====
`default_nettype none

module inst_predecode (
  input  wire logic [isa_pkg::XLEN-1:0] word_i,
  output isa_pkg::inst_kind_e           kind_o
);

  logic [6:0] opcode;
  logic       is_ctrl;
  logic       is_load;
  logic       is_fence;

  assign opcode = word_i[6:0];

  // jumps and conditional branches
  assign is_ctrl = (opcode == isa_pkg::OP_JAL) ||
                   (opcode == isa_pkg::OP_JALR) ||
                   (opcode == isa_pkg::OP_BRANCH);
  assign is_load  = (opcode == isa_pkg::OP_LOAD);
  assign is_fence = (word_i == isa_pkg::INST_FENCE_I);

  always_comb begin
    if (is_fence) begin
      kind_o = isa_pkg::KIND_FENCE;
    end else if (is_ctrl) begin
      kind_o = isa_pkg::KIND_CTRL;
    end else if (is_load) begin
      kind_o = isa_pkg::KIND_LOAD;
    end else begin
      kind_o = isa_pkg::KIND_SEQ;
    end
  end

endmodule

`default_nettype wire

// ==== source/fetch_pc.sv ====
`default_nettype none

module fetch_pc (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire logic                     advance_i,
  input  wire logic                     redirect_i,
  input  wire logic                     resume_i,
  input  wire logic [isa_pkg::XLEN-1:0] npc_i,
  output logic      [isa_pkg::XLEN-1:0] pc_o
);

  logic [isa_pkg::XLEN-1:0] pc_q;
  logic [isa_pkg::XLEN-1:0] pc_seq;

  assign pc_seq = pc_q + isa_pkg::XLEN'(4);

  // pc sits on the stalled instruction during a hazard,
  // so resume and advance share the same increment
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= isa_pkg::PC_INIT;
    end else if (redirect_i) begin
      pc_q <= npc_i;
    end else if (advance_i || resume_i) begin
      pc_q <= pc_seq;
    end
  end

  assign pc_o = pc_q;

  // the controller issues at most one command per cycle
  a_one_command: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0({advance_i, redirect_i, resume_i})
  ) else $error("fetch_pc: conflicting pc commands");

endmodule

`default_nettype wire

// ==== source/l1i_cache.sv ====
`default_nettype none

module l1i_cache #(
  parameter int SET_BITS = 1
) (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire logic [isa_pkg::XLEN-1:0] pc_i,
  input  wire logic                     invalidate_i,
  output logic                          hit_o,
  output logic      [isa_pkg::XLEN-1:0] word_o,
  output logic                          refill_idle_o,
  output logic      [isa_pkg::XLEN-1:0] araddr_o,
  output logic                          arvalid_o,
  input  wire logic [isa_pkg::XLEN-1:0] rdata_i,
  input  wire logic                     rvalid_i
);

  localparam int SETS     = 1 << SET_BITS;
  localparam int OFF_BITS = l1i_pkg::OFFSET_BITS;
  localparam int TAG_BITS = isa_pkg::XLEN - SET_BITS - OFF_BITS - 2;
  localparam int TAG_LSB  = SET_BITS + OFF_BITS + 2;

  logic [isa_pkg::XLEN-1:0] data_q [SETS][l1i_pkg::LINE_WORDS];
  logic [TAG_BITS-1:0]      tag_q  [SETS][l1i_pkg::LINE_WORDS];
  logic [SETS-1:0]          valid_q;

  l1i_pkg::refill_state_e   state_q;

  logic [TAG_BITS-1:0] addr_tag;
  logic [SET_BITS-1:0] addr_idx;
  logic [OFF_BITS-1:0] addr_off;
  logic [OFF_BITS-1:0] beat_off;
  logic                lookup_hit;
  logic                idle;

  // pc split
  assign addr_tag = pc_i[isa_pkg::XLEN-1:TAG_LSB];
  assign addr_idx = pc_i[TAG_LSB-1:OFF_BITS+2];
  assign addr_off = pc_i[OFF_BITS+1:2];

  // tag kept per word, valid per set
  assign lookup_hit = valid_q[addr_idx] && (tag_q[addr_idx][addr_off] == addr_tag);
  assign idle       = (state_q == l1i_pkg::RF_IDLE);

  assign hit_o         = idle && lookup_hit;
  assign word_o        = data_q[addr_idx][addr_off];
  assign refill_idle_o = idle;

  // beat 0 at the line base, beat 1 one word up
  assign beat_off  = (state_q == l1i_pkg::RF_BEAT1) ? OFF_BITS'(1) : '0;
  assign araddr_o  = {pc_i[isa_pkg::XLEN-1:OFF_BITS+2], beat_off, 2'b00};
  assign arvalid_o = (state_q == l1i_pkg::RF_BEAT0) || (state_q == l1i_pkg::RF_BEAT1);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= l1i_pkg::RF_IDLE;
      valid_q <= '0;
    end else begin
      case (state_q)
        l1i_pkg::RF_IDLE: begin
          if (invalidate_i) begin
            valid_q <= '0;
          end
          if (!lookup_hit) begin
            state_q <= l1i_pkg::RF_BEAT0;
          end
        end
        l1i_pkg::RF_BEAT0: begin
          if (rvalid_i) begin
            state_q <= l1i_pkg::RF_BEAT1;
          end
        end
        l1i_pkg::RF_BEAT1: begin
          if (rvalid_i) begin
            valid_q[addr_idx] <= 1'b1;
            state_q           <= l1i_pkg::RF_DONE;
          end
        end
        l1i_pkg::RF_DONE: begin
          state_q <= l1i_pkg::RF_IDLE;
        end
      endcase
    end
  end

  // line fill, one word per beat
  always_ff @(posedge clk) begin
    if (arvalid_o && rvalid_i) begin
      data_q[addr_idx][beat_off] <= rdata_i;
      tag_q[addr_idx][beat_off]  <= addr_tag;
    end
  end

  // request is a level, held until its beat returns
  a_araddr_held: assert property (
    @(posedge clk) disable iff (rst)
    arvalid_o && !rvalid_i |=> arvalid_o && $stable(araddr_o)
  ) else $error("l1i_cache: read request changed before its beat returned");

  a_no_stray_beat: assert property (
    @(posedge clk) disable iff (rst)
    idle |-> !rvalid_i
  ) else $error("l1i_cache: read data with no refill in progress");

endmodule

`default_nettype wire

// ==== source/ifu_ctrl.sv ====
`default_nettype none

module ifu_ctrl (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 hit_i,
  input  wire logic                 refill_idle_i,
  input  wire isa_pkg::inst_kind_e  kind_i,
  input  wire logic                 next_ready_i,
  input  wire logic                 pc_change_i,
  input  wire logic                 pc_retire_i,
  output logic                      valid_o,
  output logic                      advance_o,
  output logic                      redirect_o,
  output logic                      resume_o,
  output logic                      invalidate_o
);

  logic hazard_q;
  logic xfer;
  logic is_seq;
  logic resolve;

  // instruction goes out only when no earlier one is unresolved
  assign valid_o = hit_i && !hazard_q;
  assign xfer    = valid_o && next_ready_i;
  assign is_seq  = (kind_i == isa_pkg::KIND_SEQ);

  // back end answer taken only once the cache is quiet
  assign resolve = hazard_q && (pc_change_i || pc_retire_i) && refill_idle_i;

  assign advance_o    = xfer && is_seq;
  assign redirect_o   = resolve && pc_change_i;
  assign resume_o     = resolve && !pc_change_i;
  assign invalidate_o = xfer && (kind_i == isa_pkg::KIND_FENCE);

  always_ff @(posedge clk) begin
    if (rst) begin
      hazard_q <= 1'b0;
    end else if (xfer && !is_seq) begin
      hazard_q <= 1'b1;
    end else if (resolve) begin
      hazard_q <= 1'b0;
    end
  end

  // a hit from a busy cache would let pc move under a refill
  a_hit_when_idle: assert property (
    @(posedge clk) disable iff (rst)
    hit_i |-> refill_idle_i
  ) else $error("ifu_ctrl: cache hit reported while a refill is in progress");

endmodule

`default_nettype wire

// ==== source/ifu_top.sv ====
`default_nettype none

module ifu_top #(
  parameter int SET_BITS = 1
) (
  input  wire logic                     clk,
  input  wire logic                     rst,
  output logic      [isa_pkg::XLEN-1:0] araddr_o,
  output logic                          arvalid_o,
  input  wire logic [isa_pkg::XLEN-1:0] rdata_i,
  input  wire logic                     rvalid_i,
  input  wire logic [isa_pkg::XLEN-1:0] npc_i,
  input  wire logic                     pc_change_i,
  input  wire logic                     pc_retire_i,
  input  wire logic                     next_ready_i,
  output logic                          valid_o,
  output logic      [isa_pkg::XLEN-1:0] inst_o,
  output logic      [isa_pkg::XLEN-1:0] pc_o
);

  logic [isa_pkg::XLEN-1:0] pc;
  logic [isa_pkg::XLEN-1:0] word;
  logic                     hit;
  logic                     refill_idle;
  logic                     advance;
  logic                     redirect;
  logic                     resume;
  logic                     invalidate;
  isa_pkg::inst_kind_e      kind;

  ifu_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .hit_i         (hit),
    .refill_idle_i (refill_idle),
    .kind_i        (kind),
    .next_ready_i  (next_ready_i),
    .pc_change_i   (pc_change_i),
    .pc_retire_i   (pc_retire_i),
    .valid_o       (valid_o),
    .advance_o     (advance),
    .redirect_o    (redirect),
    .resume_o      (resume),
    .invalidate_o  (invalidate)
  );

  fetch_pc u_pc (
    .clk        (clk),
    .rst        (rst),
    .advance_i  (advance),
    .redirect_i (redirect),
    .resume_i   (resume),
    .npc_i      (npc_i),
    .pc_o       (pc)
  );

  l1i_cache #(
    .SET_BITS (SET_BITS)
  ) u_cache (
    .clk           (clk),
    .rst           (rst),
    .pc_i          (pc),
    .invalidate_i  (invalidate),
    .hit_o         (hit),
    .word_o        (word),
    .refill_idle_o (refill_idle),
    .araddr_o      (araddr_o),
    .arvalid_o     (arvalid_o),
    .rdata_i       (rdata_i),
    .rvalid_i      (rvalid_i)
  );

  inst_predecode u_predecode (
    .word_i (word),
    .kind_o (kind)
  );

  assign inst_o = word;
  assign pc_o   = pc;

endmodule

`default_nettype wire

// ==== dv/tb_bus_mem.sv ====
`default_nettype none

module tb_bus_mem (
  input  wire logic                     clk,
  input  wire logic                     rst,
  input  wire logic [isa_pkg::XLEN-1:0] araddr_i,
  input  wire logic                     arvalid_i,
  input  wire logic [1:0]               latency_i,
  output logic      [isa_pkg::XLEN-1:0] rdata_o,
  output logic                          rvalid_o,
  input  wire logic [isa_pkg::XLEN-1:0] peek_addr_i,
  output logic      [isa_pkg::XLEN-1:0] peek_word_o,
  output isa_pkg::inst_kind_e           peek_kind_o
);

  localparam logic [6:0] OP_IMM = 7'b001_0011;

  logic       pending;
  logic       in_rst;
  logic [1:0] wait_cnt;
  logic [1:0] lat_now;

  // word slot inside each 256-byte block sets the kind
  function automatic isa_pkg::inst_kind_e kind_at(input logic [31:0] addr);
    logic [5:0] slot;
    slot = addr[7:2];
    if (slot == 6'd17) begin
      return isa_pkg::KIND_FENCE;
    end else if (slot[2:0] == 3'd3) begin
      return isa_pkg::KIND_CTRL;
    end else if (slot[2:0] == 3'd6) begin
      return isa_pkg::KIND_LOAD;
    end
    return isa_pkg::KIND_SEQ;
  endfunction

  function automatic logic [31:0] word_at(input logic [31:0] addr);
    logic [24:0] hash;
    logic [6:0]  op;
    // every address bit lands in the upper 25 bits
    hash = addr[26:2] ^ {20'd0, addr[31:27]};
    case (kind_at(addr))
      isa_pkg::KIND_FENCE: return isa_pkg::INST_FENCE_I;
      isa_pkg::KIND_CTRL: begin
        case (addr[9:8])
          2'd0:    op = isa_pkg::OP_JAL;
          2'd2:    op = isa_pkg::OP_JALR;
          default: op = isa_pkg::OP_BRANCH;
        endcase
        return {hash, op};
      end
      isa_pkg::KIND_LOAD: return {hash, isa_pkg::OP_LOAD};
      default:            return {hash, OP_IMM};
    endcase
  endfunction

  assign peek_word_o = word_at(peek_addr_i);
  assign peek_kind_o = kind_at(peek_addr_i);

  // one beat at a time, answered 1 to 4 cycles after the request shows up
  initial begin
    rvalid_o = 1'b0;
    rdata_o  = '0;
    pending  = 1'b0;
    wait_cnt = '0;
    forever begin
      @(posedge clk);
      in_rst  = rst;
      lat_now = latency_i;
      #1;
      rvalid_o = 1'b0;
      if (in_rst) begin
        pending = 1'b0;
      end else if (pending) begin
        if (wait_cnt == 2'd0) begin
          rvalid_o = 1'b1;
          rdata_o  = word_at(araddr_i);
          pending  = 1'b0;
        end else begin
          wait_cnt = wait_cnt - 2'd1;
        end
      end else if (arvalid_i) begin
        pending  = 1'b1;
        wait_cnt = lat_now;
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_ifu.sv ====
`default_nettype none

module tb_ifu;

  localparam int SET_BITS   = 2;
  localparam int SETS       = 1 << SET_BITS;
  localparam int LINE_LSB   = l1i_pkg::OFFSET_BITS + 2;
  localparam int TAG_LSB    = LINE_LSB + SET_BITS;
  localparam int TAG_W      = isa_pkg::XLEN - TAG_LSB;
  localparam int XFER_GOAL  = 400;
  localparam int FENCE_GOAL = 2;
  localparam int RUN_LIMIT  = 20000;
  localparam int IDLE_LIMIT = 200;

  logic        clk;
  logic        rst;
  logic [31:0] araddr;
  logic        arvalid;
  logic [31:0] rdata;
  logic        rvalid;
  logic [31:0] npc;
  logic        pc_change;
  logic        pc_retire;
  logic        next_ready;
  logic        valid;
  logic [31:0] inst;
  logic [31:0] pc;
  logic [1:0]  latency;
  logic [31:0] exp_inst;
  isa_pkg::inst_kind_e exp_kind;

  logic [31:0] lfsr = 32'h1eea_2fab;
  int errors   = 0;
  int timeouts = 0;
  int xfers    = 0;
  int hazards  = 0;
  int fences   = 0;
  int refills  = 0;

  // reference state, built from bus and decode activity
  logic             seen_xfer;
  logic             hz_pending;
  logic [31:0]      hz_pc;
  logic             exp_valid;
  logic [31:0]      exp_pc;
  logic             hold_valid;
  logic [31:0]      hold_pc;
  logic [31:0]      hold_inst;
  logic             req_hold;
  logic [31:0]      req_addr;
  logic             beat1;
  logic [31:0]      beat0_addr;
  logic             done_cycle;
  logic [SETS-1:0]  line_valid;
  logic [TAG_W-1:0] line_tag [SETS];

  logic                xfer;
  logic                cache_busy;
  logic                resolve;
  logic [SET_BITS-1:0] pc_set;
  logic                model_hit;

  ifu_top #(
    .SET_BITS (SET_BITS)
  ) uut (
    .clk          (clk),
    .rst          (rst),
    .araddr_o     (araddr),
    .arvalid_o    (arvalid),
    .rdata_i      (rdata),
    .rvalid_i     (rvalid),
    .npc_i        (npc),
    .pc_change_i  (pc_change),
    .pc_retire_i  (pc_retire),
    .next_ready_i (next_ready),
    .valid_o      (valid),
    .inst_o       (inst),
    .pc_o         (pc)
  );

  tb_bus_mem u_mem (
    .clk         (clk),
    .rst         (rst),
    .araddr_i    (araddr),
    .arvalid_i   (arvalid),
    .latency_i   (latency),
    .rdata_o     (rdata),
    .rvalid_o    (rvalid),
    .peek_addr_i (pc),
    .peek_word_o (exp_inst),
    .peek_kind_o (exp_kind)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  assign xfer       = valid && next_ready;
  // beats in flight or the settle cycle after beat 1
  assign cache_busy = arvalid || done_cycle;
  assign resolve    = hz_pending && (pc_change || pc_retire) && !cache_busy;
  assign pc_set     = pc[TAG_LSB-1:LINE_LSB];
  assign model_hit  = line_valid[pc_set] && (line_tag[pc_set] == pc[isa_pkg::XLEN-1:TAG_LSB]);

  always @(posedge clk) begin
    if (rst) begin
      seen_xfer  <= 1'b0;
      hz_pending <= 1'b0;
      exp_valid  <= 1'b0;
      hold_valid <= 1'b0;
      req_hold   <= 1'b0;
      beat1      <= 1'b0;
      done_cycle <= 1'b0;
      line_valid <= '0;
    end else begin
      exp_valid  <= 1'b0;
      hold_valid <= valid && !next_ready;
      hold_pc    <= pc;
      hold_inst  <= inst;
      req_hold   <= arvalid && !rvalid;
      req_addr   <= araddr;
      done_cycle <= arvalid && rvalid && beat1;
      if (arvalid && rvalid) begin
        beat1 <= !beat1;
        if (!beat1) begin
          beat0_addr <= araddr;
        end else begin
          line_valid[araddr[TAG_LSB-1:LINE_LSB]] <= 1'b1;
          line_tag[araddr[TAG_LSB-1:LINE_LSB]]   <= araddr[isa_pkg::XLEN-1:TAG_LSB];
          refills <= refills + 1;
        end
      end
      if (xfer) begin
        seen_xfer <= 1'b1;
        xfers     <= xfers + 1;
        if (exp_kind == isa_pkg::KIND_SEQ) begin
          exp_valid <= 1'b1;
          exp_pc    <= pc + 32'd4;
        end else begin
          hz_pending <= 1'b1;
          hz_pc      <= pc;
          hazards    <= hazards + 1;
        end
        if (exp_kind == isa_pkg::KIND_FENCE) begin
          line_valid <= '0;
          fences     <= fences + 1;
        end
      end
      if (resolve) begin
        hz_pending <= 1'b0;
        exp_valid  <= 1'b1;
        exp_pc     <= pc_change ? npc : hz_pc + 32'd4;
      end
    end
  end

  a_inst_word: assert property (@(posedge clk) disable iff (rst) valid |-> inst == exp_inst)
    else begin
      errors = errors + 1;
      $display("Error %0t: inst_o = %h, expected %h", $time, $sampled(inst), $sampled(exp_inst));
    end

  a_reset_pc: assert property (@(posedge clk) disable iff (rst)
    !seen_xfer |-> pc == isa_pkg::PC_INIT)
    else begin
      errors = errors + 1;
      $display("Error %0t: pc_o = %h, expected %h", $time, $sampled(pc), isa_pkg::PC_INIT);
    end

  a_next_pc: assert property (@(posedge clk) disable iff (rst) exp_valid |-> pc == exp_pc)
    else begin
      errors = errors + 1;
      $display("Error %0t: pc_o = %h, expected %h", $time, $sampled(pc), $sampled(exp_pc));
    end

  a_hold_pc: assert property (@(posedge clk) disable iff (rst) hold_valid |-> pc == hold_pc)
    else begin
      errors = errors + 1;
      $display("Error %0t: pc_o = %h, expected %h", $time, $sampled(pc), $sampled(hold_pc));
    end

  a_hold_inst: assert property (@(posedge clk) disable iff (rst)
    hold_valid |-> inst == hold_inst)
    else begin
      errors = errors + 1;
      $display("Error %0t: inst_o = %h, expected %h", $time, $sampled(inst),
               $sampled(hold_inst));
    end

  a_stall: assert property (@(posedge clk) disable iff (rst) hz_pending |-> !valid)
    else begin
      errors = errors + 1;
      $display("Error %0t: valid_o = 1, expected 0 while pc %h is unresolved",
               $time, $sampled(hz_pc));
    end

  a_beat0_line: assert property (@(posedge clk) disable iff (rst)
    arvalid && !beat1 |-> araddr[LINE_LSB-1:0] == '0)
    else begin
      errors = errors + 1;
      $display("Error %0t: araddr_o = %h, expected a line-aligned address",
               $time, $sampled(araddr));
    end

  a_beat1_addr: assert property (@(posedge clk) disable iff (rst)
    arvalid && beat1 |-> araddr == beat0_addr + 32'd4)
    else begin
      errors = errors + 1;
      $display("Error %0t: araddr_o = %h, expected %h", $time, $sampled(araddr),
               $sampled(beat0_addr) + 32'd4);
    end

  a_req_level: assert property (@(posedge clk) disable iff (rst) req_hold |-> arvalid)
    else begin
      errors = errors + 1;
      $display("Error %0t: arvalid_o = 0, expected 1", $time);
    end

  a_req_addr: assert property (@(posedge clk) disable iff (rst) req_hold |-> araddr == req_addr)
    else begin
      errors = errors + 1;
      $display("Error %0t: araddr_o = %h, expected %h", $time, $sampled(araddr),
               $sampled(req_addr));
    end

  a_cached_no_read: assert property (@(posedge clk) disable iff (rst) model_hit |-> !arvalid)
    else begin
      errors = errors + 1;
      $display("Error %0t: arvalid_o = 1, expected 0 for cached pc %h", $time, $sampled(pc));
    end

  a_miss_read: assert property (@(posedge clk) disable iff (rst)
    !model_hit && !(arvalid && rvalid) |=> arvalid)
    else begin
      errors = errors + 1;
      $display("Error %0t: arvalid_o = 0, expected 1 for uncached pc %h", $time, $sampled(pc));
    end

  initial begin
    int          cycles;
    int          idle_cycles;
    int          last_xfers;
    int          gap;
    logic [31:0] offs;
    rst         = 1'b1;
    next_ready  = 1'b0;
    pc_change   = 1'b0;
    pc_retire   = 1'b0;
    npc         = '0;
    latency     = '0;
    cycles      = 0;
    idle_cycles = 0;
    last_xfers  = 0;
    gap         = 0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    while ((xfers < XFER_GOAL || fences < FENCE_GOAL) && timeouts == 0) begin
      @(posedge clk);
      #1;
      cycles = cycles + 1;
      if (xfers != last_xfers) begin
        idle_cycles = 0;
        last_xfers  = xfers;
      end else begin
        idle_cycles = idle_cycles + 1;
      end
      if (idle_cycles > IDLE_LIMIT) begin
        $display("Timeout: no instruction reached decode for %0d cycles", IDLE_LIMIT);
        timeouts = timeouts + 1;
      end
      if (cycles > RUN_LIMIT) begin
        $display("Timeout: run did not reach its transfer and fence goals in %0d cycles",
                 RUN_LIMIT);
        timeouts = timeouts + 1;
      end
      next_ready = (take_bits(2) != 32'd0);
      latency    = 2'(take_bits(2));
      pc_change  = 1'b0;
      pc_retire  = 1'b0;
      // back end answers after a random gap, pulses during a refill are dropped
      if (hz_pending) begin
        if (gap == 0) begin
          if (take_bits(1) != 32'd0) begin
            offs      = take_bits(6);
            npc       = isa_pkg::PC_INIT + {offs[29:0], 2'b00};
            pc_change = 1'b1;
          end else begin
            pc_retire = 1'b1;
          end
          gap = int'(take_bits(2));
        end else begin
          gap = gap - 1;
        end
      end
    end

    @(posedge clk);
    #1;
    pc_change = 1'b0;
    pc_retire = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    $display("errors %0d, timeouts %0d, transfers %0d, hazards %0d, fences %0d, refills %0d",
             errors, timeouts, xfers, hazards, fences, refills);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
source/isa_pkg.sv
source/l1i_pkg.sv
source/inst_predecode.sv
source/fetch_pc.sv
source/l1i_cache.sv
source/ifu_ctrl.sv
source/ifu_top.sv
dv/tb_bus_mem.sv
dv/tb_ifu.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_ifu
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

# the run's own status is ignored, the log decides
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
